/* dv/uart_props.sv */
// UART peripheral assertions
// APB response and serial line idle properties, bound to the top level.

`timescale 1ns/10ps

module uart_props (
    input logic               clk,
    input logic               reset,
    input uart_pkg::apb_req_t apb_req,
    input uart_pkg::apb_rsp_t apb_rsp,
    input logic               tx
);

    // failure count, read by the testbench at the end of the run
    int unsigned assert_errors = 0;

    // zero wait state slave
    a_pready_high: assert property (@(posedge clk) apb_rsp.pready)
        else begin
            $error("pready went low");
            assert_errors++;
        end

    a_pslverr_in_access: assert property (@(posedge clk)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("pslverr raised outside an access phase");
            assert_errors++;
        end

    // line idles high while held in reset
    a_tx_idle_in_reset: assert property (@(posedge clk) reset |=> tx)
        else begin
            $error("tx line not high during reset");
            assert_errors++;
        end

endmodule

bind uart_apb_top uart_props u_props (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .tx      (tx)
);

/* dv/uart_tb.sv */
// UART peripheral testbench
// Drives the APB port, loops tx back to rx and checks register reads
// against a reference model of the RX FIFO, flags and divider.

`timescale 1ns/10ps

module uart_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int SAMPLE_DELAY = 10;
    localparam int FIFO_DEPTH   = 8;
    localparam int MAX_WAIT     = 20000;
    localparam logic [3:0] UNMAPPED = uart_pkg::REG_DIVIDER + 4'h2;

    logic               clk;
    logic               reset;
    uart_pkg::apb_req_t apb_req;
    uart_pkg::apb_rsp_t apb_rsp;
    logic               tx;
    logic               rx;
    logic               irq;
    logic               loopback;
    logic               rx_drv;
    int                 errors;
    int                 checks;

    // reference model state
    logic [7:0]  rx_model_q[$];
    logic        exp_overrun;
    logic        exp_frame_err;
    logic [15:0] exp_divider;

    assign rx = loopback ? tx : rx_drv;

    uart_apb_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_uart_apb_top (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .rx      (rx),
        .apb_rsp (apb_rsp),
        .tx      (tx),
        .irq     (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] status_word(input logic tx_full, input logic tx_empty,
                                                input logic rx_full, input logic rx_empty,
                                                input logic rx_overrun, input logic frame_err);
        uart_pkg::status_t s;
        s.tx_full    = tx_full;
        s.tx_empty   = tx_empty;
        s.rx_full    = rx_full;
        s.rx_empty   = rx_empty;
        s.rx_overrun = rx_overrun;
        s.frame_err  = frame_err;
        return 32'(s);
    endfunction

    // transmitter assumed drained whenever STATUS is compared
    function automatic logic [31:0] model_read(input logic [3:0] addr);
        logic [31:0] result;
        result = '0;
        if (addr == uart_pkg::REG_RXDATA) begin
            if (rx_model_q.size() > 0) begin
                result = 32'(rx_model_q.pop_front());
            end
        end
        else if (addr == uart_pkg::REG_STATUS) begin
            result = status_word(1'b0, 1'b1, rx_model_q.size() == FIFO_DEPTH,
                                 rx_model_q.size() == 0, exp_overrun, exp_frame_err);
            exp_overrun   = 1'b0;
            exp_frame_err = 1'b0;
        end
        else if (addr == uart_pkg::REG_DIVIDER) begin
            result = 32'(exp_divider);
        end
        return result;
    endfunction

    // byte written to TXDATA ends up in the RX FIFO through loopback
    function automatic void model_write(input logic [3:0] addr, input logic [31:0] data);
        if (addr == uart_pkg::REG_TXDATA) begin
            if (rx_model_q.size() < FIFO_DEPTH) begin
                rx_model_q.push_back(data[7:0]);
            end
            else begin
                exp_overrun = 1'b1;
            end
        end
        else if (addr == uart_pkg::REG_DIVIDER) begin
            exp_divider = data[15:0];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // APB transfers, entered on a falling edge
    // ------------------------------------------------------------
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b1;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(SAMPLE_DELAY);
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(SAMPLE_DELAY);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [3:0] addr, input logic exp_err);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(name, model_read(addr), data);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic write_check(input string name, input logic [3:0] addr,
                               input logic [31:0] data, input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        model_write(addr, data);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    // ------------------------------------------------------------
    // bounded waits
    // ------------------------------------------------------------
    task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
                               input string what, output logic [31:0] last);
        int   polls;
        logic err;
        polls = 0;
        apb_read(uart_pkg::REG_STATUS, last, err);
        while (((last & mask) != want) && polls < MAX_WAIT) begin
            apb_read(uart_pkg::REG_STATUS, last, err);
            polls++;
        end
        if ((last & mask) != want) begin
            errors++;
            $display("timeout waiting for %s in the status register", what);
        end
    endtask

    task automatic wait_irq(input string what);
        int cycles;
        cycles = 0;
        while (!irq && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq) begin
            errors++;
            $display("timeout waiting for the receive interrupt in %s", what);
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [31:0] st;
        wait_status(status_word(1, 0, 0, 0, 0, 0), '0, "TX FIFO space", st);
        write_check("txdata write", uart_pkg::REG_TXDATA, 32'(data), 1'b0);
    endtask

    task automatic loopback_burst(input string name, input int count);
        for (int i = 0; i < count; i++) begin
            send_byte(8'($urandom_range(255, 0)));
        end
        for (int i = 0; i < count; i++) begin
            wait_irq(name);
            read_check($sformatf("%s byte %0d", name, i), uart_pkg::REG_RXDATA, 1'b0);
        end
        read_check({name, " status"}, uart_pkg::REG_STATUS, 1'b0);
    endtask

    // serial frame driven straight onto rx
    task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
        int bit_clks;
        bit_clks = (int'(exp_divider) + 1) * uart_pkg::OVERSAMPLE;
        rx_drv = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx_drv = data[i];
            repeat (bit_clks) @(negedge clk);
        end
        rx_drv = stop_bit;
        repeat (bit_clks) @(negedge clk);
        rx_drv = 1'b1;
        repeat (bit_clks) @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] st;
        logic [15:0] new_div;
        void'($urandom(82));
        clk           = 1'b0;
        reset         = 1'b1;
        apb_req       = '0;
        // rx held idle until tx comes out of reset
        loopback      = 1'b0;
        rx_drv        = 1'b1;
        errors        = 0;
        checks        = 0;
        exp_overrun   = 1'b0;
        exp_frame_err = 1'b0;
        exp_divider   = 16'd4;
        repeat (4) @(negedge clk);
        reset    = 1'b0;
        loopback = 1'b1;

        // reset state
        read_check("reset status", uart_pkg::REG_STATUS, 1'b0);
        read_check("reset divider", uart_pkg::REG_DIVIDER, 1'b0);
        check_value("reset irq", '0, 32'(irq));

        loopback_burst("loopback", 6);

        // new bit rate, then loop back again
        new_div = 16'($urandom_range(9, 2));
        write_check("divider write", uart_pkg::REG_DIVIDER, 32'(new_div), 1'b0);
        read_check("divider readback", uart_pkg::REG_DIVIDER, 1'b0);
        loopback_burst("divider burst", 4);

        // overrun with reads held off
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_byte(8'($urandom_range(255, 0)));
        end
        wait_status(status_word(0, 1, 0, 0, 1, 0), status_word(0, 1, 0, 0, 1, 0),
                    "receive overrun", st);
        check_value("overrun status", model_read(uart_pkg::REG_STATUS), st);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_check($sformatf("overrun byte %0d", i), uart_pkg::REG_RXDATA, 1'b0);
        end
        read_check("overrun cleared", uart_pkg::REG_STATUS, 1'b0);

        // low stop bit
        loopback = 1'b0;
        drive_frame(8'($urandom_range(255, 0)), 1'b0);
        exp_frame_err = 1'b1;
        wait_status(status_word(0, 0, 0, 0, 0, 1), status_word(0, 0, 0, 0, 0, 1),
                    "framing error", st);
        check_value("framing status", model_read(uart_pkg::REG_STATUS), st);
        loopback = 1'b1;

        // bus errors leave the state alone
        read_check("unmapped read", UNMAPPED, 1'b1);
        write_check("status write", uart_pkg::REG_STATUS, 32'h3f, 1'b1);
        write_check("rxdata write", uart_pkg::REG_RXDATA, 32'h5a, 1'b1);
        read_check("status after bus errors", uart_pkg::REG_STATUS, 1'b0);
        read_check("divider after bus errors", uart_pkg::REG_DIVIDER, 1'b0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_uart_apb_top.u_props.assert_errors);
        if (errors == 0 && u_uart_apb_top.u_props.assert_errors == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_fifo.sv
source/uart_apb_regs.sv
source/uart_apb_top.sv
dv/uart_props.sv
dv/uart_tb.sv

/* source/uart_apb_regs.sv */
// UART APB register block
// Decodes the access phase against the register map, drives the FIFO
// push and pop strobes, holds the divider and the sticky error flags.
// Zero wait states; pslverr flags unmapped and read-only writes.

`timescale 1ns/10ps

module uart_apb_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  uart_pkg::apb_req_t             apb_req,
    input  logic                           tx_full,
    input  logic                           tx_empty,
    input  logic                           rx_full,
    input  logic                           rx_empty,
    input  logic [7:0]                     rx_rdata,
    input  logic                           rx_push_lost,
    input  logic                           frame_err_pulse,
    output uart_pkg::apb_rsp_t             apb_rsp,
    output logic                           tx_push,
    output logic [7:0]                     tx_wdata,
    output logic                           rx_pop,
    output logic [uart_pkg::DIV_WIDTH-1:0] divider,
    output logic                           irq
);

    localparam logic [uart_pkg::DIV_WIDTH-1:0] DIV_RESET = uart_pkg::DIV_WIDTH'(4);

    logic               access;
    logic               wr_access;
    logic               rd_access;
    logic               hit_tx;
    logic               hit_rx;
    logic               hit_st;
    logic               hit_div;
    logic               bad_access;
    logic               status_rd;
    logic               rx_overrun;
    logic               frame_err;
    uart_pkg::status_t  status;
    logic [31:0]        rdata;

    // ------------------------------------------------------------
    // address decode, access phase only
    // ------------------------------------------------------------
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    assign hit_tx  = (apb_req.paddr == uart_pkg::REG_TXDATA);
    assign hit_rx  = (apb_req.paddr == uart_pkg::REG_RXDATA);
    assign hit_st  = (apb_req.paddr == uart_pkg::REG_STATUS);
    assign hit_div = (apb_req.paddr == uart_pkg::REG_DIVIDER);

    // RXDATA and STATUS are read-only
    assign bad_access = access &&
                        (!(hit_tx || hit_rx || hit_st || hit_div) ||
                         (apb_req.pwrite && (hit_rx || hit_st)));

    // fifo strobes
    assign tx_push   = wr_access && hit_tx;
    assign tx_wdata  = apb_req.pwdata[7:0];
    assign rx_pop    = rd_access && hit_rx;
    assign status_rd = rd_access && hit_st;

    // ------------------------------------------------------------
    // divider and sticky flags
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            divider    <= DIV_RESET;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end
        else begin
            if (wr_access && hit_div) begin
                divider <= apb_req.pwdata[uart_pkg::DIV_WIDTH-1:0];
            end
            if (status_rd) begin
                rx_overrun <= 1'b0;
                frame_err  <= 1'b0;
            end
            // receiver strobe meeting a full fifo is a lost byte;
            // a new event wins over a clear in the same cycle
            if (rx_push_lost && rx_full) begin
                rx_overrun <= 1'b1;
            end
            if (frame_err_pulse) begin
                frame_err <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    always_comb begin
        status.tx_full    = tx_full;
        status.tx_empty   = tx_empty;
        status.rx_full    = rx_full;
        status.rx_empty   = rx_empty;
        status.rx_overrun = rx_overrun;
        status.frame_err  = frame_err;

        rdata = '0;
        if (hit_rx && !rx_empty) begin
            rdata = 32'(rx_rdata);
        end
        else if (hit_st) begin
            rdata = 32'(status);
        end
        else if (hit_div) begin
            rdata = 32'(divider);
        end
    end

    always_comb begin
        apb_rsp.prdata  = rd_access ? rdata : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = bad_access;
    end

    // level interrupt while received data waits
    assign irq = !rx_empty;

endmodule

/* source/uart_apb_top.sv */
// UART peripheral top level
// APB slave registers, TX and RX byte FIFOs, baud generator,
// serial transmitter and receiver.

`timescale 1ns/10ps

module uart_apb_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::apb_req_t apb_req,
    input  logic               rx,
    output uart_pkg::apb_rsp_t apb_rsp,
    output logic               tx,
    output logic               irq
);

    logic                           tick;
    logic [uart_pkg::DIV_WIDTH-1:0] divider;

    // transmit path
    logic       tx_push;
    logic [7:0] tx_wdata;
    logic [7:0] tx_data;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_valid;
    logic       tx_ready;

    // receive path
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_frame_err;
    logic       rx_pop;
    logic [7:0] rx_rdata;
    logic       rx_full;
    logic       rx_empty;

    assign tx_valid = !tx_empty;

    // ------------------------------------------------------------
    // register block
    // ------------------------------------------------------------
    uart_apb_regs u_regs (
        .clk             (clk),
        .reset           (reset),
        .apb_req         (apb_req),
        .tx_full         (tx_full),
        .tx_empty        (tx_empty),
        .rx_full         (rx_full),
        .rx_empty        (rx_empty),
        .rx_rdata        (rx_rdata),
        .rx_push_lost    (rx_valid),
        .frame_err_pulse (rx_frame_err),
        .apb_rsp         (apb_rsp),
        .tx_push         (tx_push),
        .tx_wdata        (tx_wdata),
        .rx_pop          (rx_pop),
        .divider         (divider),
        .irq             (irq)
    );

    // ------------------------------------------------------------
    // FIFOs
    // ------------------------------------------------------------
    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_valid && tx_ready),
        .rdata (tx_data),
        .full  (tx_full),
        .empty (tx_empty)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (rx_valid),
        .wdata (rx_data),
        .pop   (rx_pop),
        .rdata (rx_rdata),
        .full  (rx_full),
        .empty (rx_empty)
    );

    // ------------------------------------------------------------
    // serial side
    // ------------------------------------------------------------
    uart_baud_gen u_baud_gen (
        .clk     (clk),
        .reset   (reset),
        .divider (divider),
        .tick    (tick)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

    uart_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .frame_err (rx_frame_err)
    );

endmodule

/* source/uart_baud_gen.sv */
// UART baud generator
// Down-counter reloaded from the divider register. Emits a single
// cycle oversampling tick once every divider+1 clocks.

`timescale 1ns/10ps

module uart_baud_gen (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [uart_pkg::DIV_WIDTH-1:0] divider,
    output logic                           tick
);

    logic [uart_pkg::DIV_WIDTH-1:0] count;

    // divider is only sampled at reload, so a new value
    // takes effect after the current period runs out
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == '0) begin
            count <= divider;
            tick  <= 1'b1;
        end
        else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

/* source/uart_fifo.sv */
// UART byte FIFO
// Synchronous circular buffer with occupancy count. Head entry is
// shown on rdata. Push when full and pop when empty are ignored.

`timescale 1ns/10ps

module uart_fifo #(
    parameter int DEPTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] wdata,
    input  logic       pop,
    output logic [7:0] rdata,
    output logic       full,
    output logic       empty
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];
    assign full  = (count == (AW + 1)'(DEPTH));
    assign empty = (count == '0);

endmodule

/* source/uart_pkg.sv */
// UART peripheral shared definitions
// APB request and response bundles, register map offsets,
// the status word layout and the oversampling constant

package uart_pkg;

    // ------------------------------------------------------------
    // APB bus bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------
    localparam logic [3:0] REG_TXDATA  = 4'h0;
    localparam logic [3:0] REG_RXDATA  = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_DIVIDER = 4'hC;

    // low 6 bits of STATUS, frame_err in bit 0
    typedef struct packed {
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_empty;
        logic rx_overrun;
        logic frame_err;
    } status_t;

    // ticks per bit and width of the baud divider
    localparam int OVERSAMPLE = 8;
    localparam int DIV_WIDTH  = 16;

endpackage

/* source/uart_rx.sv */
// UART serial receiver
// Synchronizes the line, detects a falling start edge, samples each
// bit on the 4th tick of its period and checks the stop bit.

`timescale 1ns/10ps

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       rx,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    output logic       frame_err
);

    localparam int OS_BITS = $clog2(uart_pkg::OVERSAMPLE);
    localparam logic [OS_BITS-1:0] SAMPLE_AT = OS_BITS'(uart_pkg::OVERSAMPLE / 2 - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t             state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_last;
    logic [OS_BITS-1:0] tick_cnt;
    logic [2:0]         bit_cnt;
    logic [7:0]         shift;
    logic               sample;

    // ------------------------------------------------------------
    // two-flop synchronizer, idles high
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // mid-bit sample point
    assign sample = tick && (tick_cnt == SAMPLE_AT);

    // ------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            rx_last   <= 1'b1;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end
        else begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            if (tick) begin
                rx_last  <= rx_sync;
                tick_cnt <= tick_cnt + 1'b1;
                case (state)
                    S_IDLE: begin
                        // edge tick counts as tick 0 of the start bit
                        if (rx_last && !rx_sync) begin
                            state    <= S_START;
                            tick_cnt <= OS_BITS'(1);
                        end
                    end
                    S_START: begin
                        if (sample) begin
                            // glitch if the line is back high
                            state   <= rx_sync ? S_IDLE : S_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    S_DATA: begin
                        if (sample) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= S_STOP;
                            end
                        end
                    end
                    S_STOP: begin
                        if (sample) begin
                            state     <= S_IDLE;
                            rx_valid  <= rx_sync;
                            frame_err <= !rx_sync;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample && state == S_DATA) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_data = shift;

endmodule

/* source/uart_tx.sv */
// UART serial transmitter
// Takes one byte on a tick when idle and shifts out a frame of
// start bit, 8 data bits LSB first and two idle-high bit periods.

`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);

    localparam int OS_BITS    = $clog2(uart_pkg::OVERSAMPLE);
    localparam int FRAME_BITS = 11;

    logic       tx_busy;
    logic [6:0] tx_count;
    // bit 0 drives the line
    logic [8:0] tx_buf;

    // ------------------------------------------------------------
    // frame sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy   <= 1'b0;
            tx_count  <= '0;
            tx_buf[0] <= 1'b1;
        end
        else if (tick) begin
            if (!tx_busy) begin
                if (tx_valid) begin
                    tx_busy     <= 1'b1;
                    tx_count    <= '0;
                    // start bit goes out on this edge
                    tx_buf      <= {tx_data, 1'b0};
                end
            end
            else begin
                tx_count <= tx_count + 1'b1;
                if (tx_count[OS_BITS-1:0] == OS_BITS'(uart_pkg::OVERSAMPLE - 1)) begin
                    // shift ones in behind the data
                    tx_buf <= {1'b1, tx_buf[8:1]};
                    if (tx_count[6:OS_BITS] == (7 - OS_BITS)'(FRAME_BITS - 1)) begin
                        tx_busy <= 1'b0;
                    end
                end
            end
        end
    end

    // a byte moves only on a tick cycle
    assign tx_ready = !tx_busy && tick;
    assign tx       = tx_buf[0];

endmodule
